// ==== hdl/dma_chan.sv ====
// ********************
// one DMA channel
// base and current address and count, the mode bits
// and the transfer FSM that drives the memory strobes
// ********************

`timescale 1ns/10ps

module dma_chan #(
	parameter int CH_NUM = 0,
	parameter int DATA_W = dma_pkg::DATA_W,
	parameter int ADDR_W = dma_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ch_clear,
	input  logic [3:0]        io_address,
	input  logic [DATA_W-1:0] io_writedata,
	input  logic              reg_write,
	input  logic              ff,
	input  logic              grant,
	input  logic [DATA_W-1:0] dev_wdata_ch,
	input  logic [DATA_W-1:0] mem_readdata,
	input  logic              mem_readdatavalid,
	input  logic              mem_waitrequest,
	output logic [DATA_W-1:0] rdata,
	output logic              busy,
	output logic              auto_init,
	output logic              tc_int,
	output logic              dack_ch,
	output logic              tc_ch,
	output logic [DATA_W-1:0] dev_rdata_ch,
	output logic [ADDR_W-1:0] ch_address,
	output logic              ch_read,
	output logic              ch_write,
	output logic [DATA_W-1:0] ch_wdata
);

	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_START  = 3'd1;
	localparam logic [2:0] ST_ISSUE  = 3'd2;
	localparam logic [2:0] ST_WAIT   = 3'd3;
	localparam logic [2:0] ST_DATA   = 3'd4;
	localparam logic [2:0] ST_VERIFY = 3'd5;
	localparam logic [2:0] ST_UPDATE = 3'd6;
	localparam logic [2:0] ST_DONE   = 3'd7;

	logic [2:0]        state;
	logic [ADDR_W-1:0] base_addr;
	logic [ADDR_W-1:0] cur_addr;
	logic [ADDR_W-1:0] base_cnt;
	logic [ADDR_W-1:0] cur_cnt;
	logic [1:0]        xfer;
	logic              dec;
	logic              is_read;
	logic              is_write;
	logic              strobe;
	logic              sel_addr;
	logic              sel_cnt;
	logic              sel_mode;
	logic [DATA_W-1:0] wdata_q;
	dma_pkg::dma_cmd_u cmd;

	assign cmd      = io_writedata;
	assign sel_addr = io_address == 4'(2 * CH_NUM);
	assign sel_cnt  = io_address == 4'(2 * CH_NUM + 1);
	assign sel_mode = reg_write && io_address == dma_pkg::REG_MODE &&
		cmd.mode_view.ch_sel == 2'(CH_NUM);

	assign rdata = sel_addr ? cur_addr[ff * DATA_W +: DATA_W] :
		sel_cnt ? cur_cnt[ff * DATA_W +: DATA_W] : '0;

	// ********************
	// address and count registers written one byte per access

	always_ff @(posedge clk) begin
		if (reg_write && sel_addr) begin
			base_addr[ff * DATA_W +: DATA_W] <= io_writedata;
			cur_addr[ff * DATA_W +: DATA_W]  <= io_writedata;
		end else if (tc_int && auto_init)
			cur_addr <= base_addr;
		else if (state == ST_UPDATE)
			cur_addr <= dec ? cur_addr - 1'b1 : cur_addr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reg_write && sel_cnt) begin
			base_cnt[ff * DATA_W +: DATA_W] <= io_writedata;
			cur_cnt[ff * DATA_W +: DATA_W]  <= io_writedata;
		end else if (tc_int && auto_init)
			cur_cnt <= base_cnt;
		else if (state == ST_UPDATE)
			cur_cnt <= cur_cnt - 1'b1;  // wraps to all ones after terminal count
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			xfer      <= dma_pkg::XFER_VERIFY;
			auto_init <= 1'b0;
			dec       <= 1'b0;
		end else if (sel_mode) begin
			xfer      <= cmd.mode_view.xfer;
			auto_init <= cmd.mode_view.auto_init;
			dec       <= cmd.mode_view.dec;
		end
	end

	// ********************
	// transfer FSM

	assign is_read  = xfer == dma_pkg::XFER_READ;
	assign is_write = xfer == dma_pkg::XFER_WRITE;

	always_ff @(posedge clk) begin
		if (!rst_n || ch_clear)
			state <= ST_IDLE;
		else begin
			case (state)
				ST_IDLE:   if (grant) state <= ST_START;
				ST_START:  state <= (is_read || is_write) ? ST_ISSUE : ST_VERIFY;
				ST_ISSUE:  state <= ST_WAIT;  // the memory sees the strobe from here on
				ST_WAIT:   if (!mem_waitrequest) state <= is_read ? ST_DATA : ST_UPDATE;
				ST_DATA:   if (mem_readdatavalid) state <= ST_UPDATE;
				ST_VERIFY: state <= ST_UPDATE;
				ST_UPDATE: state <= ST_DONE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_START)
			wdata_q <= dev_wdata_ch;
		if (state == ST_DATA && mem_readdatavalid)
			dev_rdata_ch <= mem_readdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			tc_ch <= 1'b0;
		else
			tc_ch <= tc_int;
	end

	// the strobe drops in the cycle the memory accepts, since the memory port adds a register
	assign strobe     = state == ST_ISSUE || (state == ST_WAIT && mem_waitrequest);
	assign ch_read    = is_read && strobe;
	assign ch_write   = is_write && strobe;
	assign busy       = state != ST_IDLE;
	assign ch_address = busy ? cur_addr : '0;
	assign ch_wdata   = busy ? wdata_q : '0;
	assign dack_ch    = state == ST_UPDATE;
	assign tc_int     = dack_ch && cur_cnt == '0;

	a_grant_idle: assert property (@(posedge clk) disable iff (!rst_n)
		grant |-> state == ST_IDLE);

	// read data only arrives while the FSM waits for it
	a_valid_in_data: assert property (@(posedge clk) disable iff (!rst_n)
		busy && is_read && mem_readdatavalid |-> state == ST_DATA);

endmodule

// ==== hdl/dma_mem_port.sv ====
// ********************
// fixed-priority arbiter with channel 0 first
// memory bus master that registers the channel signals once
// and puts the page byte of the busy channel on top
// ********************

`timescale 1ns/10ps

module dma_mem_port #(
	parameter int NUM_CH     = dma_pkg::NUM_CH,
	parameter int DATA_W     = dma_pkg::DATA_W,
	parameter int ADDR_W     = dma_pkg::ADDR_W,
	parameter int PAGE_W     = dma_pkg::PAGE_W,
	parameter int MEM_ADDR_W = dma_pkg::MEM_ADDR_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [NUM_CH-1:0]             req_active,
	input  logic                          disabled,
	input  logic [NUM_CH-1:0]             busy,
	input  logic [NUM_CH-1:0][PAGE_W-1:0] page,
	input  logic [NUM_CH-1:0][ADDR_W-1:0] ch_address,
	input  logic [NUM_CH-1:0]             ch_read,
	input  logic [NUM_CH-1:0]             ch_write,
	input  logic [NUM_CH-1:0][DATA_W-1:0] ch_wdata,
	output logic [NUM_CH-1:0]             grant,
	output logic [MEM_ADDR_W-1:0]         mem_address,
	output logic                          mem_read,
	output logic                          mem_write,
	output logic [DATA_W-1:0]             mem_writedata
);

	logic [ADDR_W-1:0] addr_or;
	logic [PAGE_W-1:0] page_sel;
	logic [DATA_W-1:0] wdata_or;
	logic              read_or;
	logic              write_or;

	// the grant is the lowest set bit of the active requests and stays empty while a transfer runs
	assign grant = (disabled || |busy) ? '0 : req_active & (~req_active + NUM_CH'(1));

	// idle channels drive zeros, so an OR merges them
	always_comb begin
		addr_or  = '0;
		page_sel = '0;
		wdata_or = '0;
		read_or  = 1'b0;
		write_or = 1'b0;
		for (int i = 0; i < NUM_CH; i++) begin
			addr_or  |= ch_address[i];
			wdata_or |= ch_wdata[i];
			read_or  |= ch_read[i];
			write_or |= ch_write[i];
			if (busy[i])
				page_sel |= page[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end else if (|busy) begin
			mem_read  <= read_or;
			mem_write <= write_or;
		end else begin
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (|busy) begin
			mem_address   <= {page_sel, addr_or};
			mem_writedata <= wdata_or;
		end
	end

	// the OR merge above relies on a single running channel
	a_one_busy: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(busy));

endmodule

// ==== hdl/dma_pkg.sv ====
// ********************
// shared definitions of the byte-wide DMA controller
// widths, port register offsets, transfer codes, the page
// port map and the command byte with its two decodings
// ********************

package dma_pkg;

	// ********************
	// widths

	localparam int DATA_W     = 8;   // the CPU port and the memory bus are a byte wide
	localparam int ADDR_W     = 16;  // channel address and count registers
	localparam int PAGE_W     = 8;   // page byte placed above the channel address
	localparam int MEM_ADDR_W = 24;
	localparam int NUM_CH     = 4;

	// ********************
	// controller port offsets, channel n sits at 2n and 2n+1

	localparam logic [3:0] REG_STATUS_CMD  = 4'd8;   // status on read, command on write
	localparam logic [3:0] REG_REQUEST     = 4'd9;
	localparam logic [3:0] REG_MASK_SINGLE = 4'd10;
	localparam logic [3:0] REG_MODE        = 4'd11;
	localparam logic [3:0] REG_CLR_FF      = 4'd12;
	localparam logic [3:0] REG_MASTER_CLR  = 4'd13;
	localparam logic [3:0] REG_CLR_MASK    = 4'd14;
	localparam logic [3:0] REG_MASK_ALL    = 4'd15;  // also reads back the mask

	// transfer type field of the mode byte
	localparam logic [1:0] XFER_VERIFY = 2'd0;
	localparam logic [1:0] XFER_WRITE  = 2'd1;  // device to memory
	localparam logic [1:0] XFER_READ   = 2'd2;  // memory to device

	// page port offset of each channel, channel 0 is the rightmost entry
	localparam logic [NUM_CH-1:0][3:0] PAGE_OFFS = {4'd2, 4'd1, 4'd3, 4'd7};

	// ********************
	// the byte written to the mode, mask and request ports

	typedef union packed {
		struct packed {
			logic [1:0] mode;       // demand, single, block or cascade
			logic       dec;        // address steps down
			logic       auto_init;  // reload base values after terminal count
			logic [1:0] xfer;
			logic [1:0] ch_sel;
		} mode_view;
		struct packed {
			logic [4:0] unused;
			logic       set;        // set the bit when high, clear it when low
			logic [1:0] ch_sel;
		} sel_view;
	} dma_cmd_u;

endpackage

// ==== hdl/dma_regs.sv ====
// ********************
// register block of the DMA controller
// CPU port decode, byte pointer, mask, request and status bits,
// the disable bit, the page bytes and the readback register
// ********************

`timescale 1ns/10ps

module dma_regs #(
	parameter int NUM_CH = dma_pkg::NUM_CH,
	parameter int DATA_W = dma_pkg::DATA_W,
	parameter int PAGE_W = dma_pkg::PAGE_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [3:0]                    io_address,
	input  logic                          io_read,
	input  logic                          io_write,
	input  logic                          io_cs,
	input  logic                          io_page_cs,
	input  logic [DATA_W-1:0]             io_writedata,
	output logic [DATA_W-1:0]             io_readdata,
	input  logic [NUM_CH-1:0][DATA_W-1:0] chan_rdata,
	input  logic [NUM_CH-1:0]             tc_int,
	input  logic [NUM_CH-1:0]             auto_init,
	input  logic [NUM_CH-1:0]             dreq,
	output logic                          reg_write,
	output logic                          ff,
	output logic                          ch_clear,
	output logic                          disabled,
	output logic [NUM_CH-1:0]             req_active,
	output logic [NUM_CH-1:0][PAGE_W-1:0] page
);

	logic              rd_last;
	logic              wr_last;
	logic              read_edge;
	logic              ctrl_read;
	logic              page_write;
	logic [NUM_CH-1:0] sel_bit;
	logic [NUM_CH-1:0] sw_req;
	logic [NUM_CH-1:0] pending;
	logic [NUM_CH-1:0] mask;
	logic [NUM_CH-1:0] terminated;
	logic [DATA_W-1:0] chan_or;
	logic [DATA_W-1:0] rd_mux;
	dma_pkg::dma_cmd_u cmd;

	// ********************
	// port decode

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_last <= 1'b0;
			wr_last <= 1'b0;
		end else begin
			rd_last <= io_read & (io_cs | io_page_cs);
			wr_last <= io_write & io_cs;
		end
	end

	assign read_edge  = io_read & (io_cs | io_page_cs) & ~rd_last;  // only the first cycle counts
	assign ctrl_read  = read_edge & io_cs;
	assign reg_write  = io_write & io_cs & ~wr_last;
	assign page_write = io_write & io_page_cs;
	assign ch_clear   = reg_write && io_address == dma_pkg::REG_MASTER_CLR;

	assign cmd     = io_writedata;
	assign sel_bit = NUM_CH'(1) << cmd.sel_view.ch_sel;

	// ********************
	// control state

	// the byte pointer steps on every access to an address or count port
	always_ff @(posedge clk) begin
		if (!rst_n || ch_clear)
			ff <= 1'b0;
		else if (reg_write && io_address == dma_pkg::REG_CLR_FF)
			ff <= 1'b0;
		else if ((reg_write || ctrl_read) && !io_address[3])
			ff <= ~ff;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ch_clear)
			disabled <= 1'b0;
		else if (reg_write && io_address == dma_pkg::REG_STATUS_CMD)
			disabled <= io_writedata[2];  // the disable bit is all that is left of the command
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ch_clear)
			mask <= '1;
		else if (reg_write && io_address == dma_pkg::REG_CLR_MASK)
			mask <= '0;
		else if (reg_write && io_address == dma_pkg::REG_MASK_ALL)
			mask <= io_writedata[NUM_CH-1:0];
		else if (reg_write && io_address == dma_pkg::REG_MASK_SINGLE)
			mask <= cmd.sel_view.set ? (mask | sel_bit) : (mask & ~sel_bit);
		else
			mask <= mask | (tc_int & ~auto_init);  // a channel without auto-init stops itself
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ch_clear)
			sw_req <= '0;
		else if (reg_write && io_address == dma_pkg::REG_REQUEST)
			sw_req <= cmd.sel_view.set ? (sw_req | sel_bit) : (sw_req & ~sel_bit);
		else
			sw_req <= sw_req & ~tc_int;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ch_clear)
			terminated <= '0;
		else if (ctrl_read && io_address == dma_pkg::REG_STATUS_CMD)
			terminated <= '0;  // reading the status clears it
		else
			terminated <= terminated | tc_int;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			page <= '0;
		else if (page_write) begin
			for (int i = 0; i < NUM_CH; i++)
				if (io_address == dma_pkg::PAGE_OFFS[i])
					page[i] <= io_writedata;
		end
	end

	assign pending    = dreq | sw_req;
	assign req_active = pending & ~mask;

	// ********************
	// readback

	always_comb begin
		chan_or = '0;
		for (int i = 0; i < NUM_CH; i++)
			chan_or |= chan_rdata[i];  // only the addressed channel drives a byte
		rd_mux = '0;
		if (io_page_cs && !io_cs) begin
			for (int i = 0; i < NUM_CH; i++)
				if (io_address == dma_pkg::PAGE_OFFS[i])
					rd_mux = page[i];
		end else if (!io_address[3])
			rd_mux = chan_or;
		else if (io_address == dma_pkg::REG_STATUS_CMD)
			rd_mux = {pending, terminated};
		else if (io_address == dma_pkg::REG_MASK_ALL)
			rd_mux = {{(DATA_W - NUM_CH){1'b1}}, mask};
	end

	always_ff @(posedge clk) begin
		if (read_edge)
			io_readdata <= rd_mux;  // held until the next read
	end

	// channels run one at a time, so no two reach terminal count together
	a_one_tc: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(tc_int));

endmodule

// ==== hdl/dma_top.sv ====
// ********************
// four-channel byte-wide DMA controller with page registers
// register block, four channel engines and the memory port
// ********************

`timescale 1ns/10ps

module dma_top #(
	parameter int NUM_CH     = dma_pkg::NUM_CH,
	parameter int DATA_W     = dma_pkg::DATA_W,
	parameter int ADDR_W     = dma_pkg::ADDR_W,
	parameter int PAGE_W     = dma_pkg::PAGE_W,
	parameter int MEM_ADDR_W = dma_pkg::MEM_ADDR_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [3:0]                    io_address,
	input  logic                          io_read,
	input  logic                          io_write,
	input  logic                          io_cs,
	input  logic                          io_page_cs,
	input  logic [DATA_W-1:0]             io_writedata,
	output logic [DATA_W-1:0]             io_readdata,
	output logic [MEM_ADDR_W-1:0]         mem_address,
	output logic                          mem_read,
	output logic                          mem_write,
	output logic [DATA_W-1:0]             mem_writedata,
	input  logic [DATA_W-1:0]             mem_readdata,
	input  logic                          mem_readdatavalid,
	input  logic                          mem_waitrequest,
	input  logic [NUM_CH-1:0]             dreq,
	output logic [NUM_CH-1:0]             dack,
	output logic [NUM_CH-1:0]             tc,
	input  logic [NUM_CH-1:0][DATA_W-1:0] dev_wdata,
	output logic [NUM_CH-1:0][DATA_W-1:0] dev_rdata
);

	logic                          reg_write;
	logic                          ff;
	logic                          ch_clear;
	logic                          disabled;
	logic [NUM_CH-1:0]             req_active;
	logic [NUM_CH-1:0]             grant;
	logic [NUM_CH-1:0]             busy;
	logic [NUM_CH-1:0]             auto_init;
	logic [NUM_CH-1:0]             tc_int;
	logic [NUM_CH-1:0]             ch_read;
	logic [NUM_CH-1:0]             ch_write;
	logic [NUM_CH-1:0][DATA_W-1:0] chan_rdata;
	logic [NUM_CH-1:0][DATA_W-1:0] ch_wdata;
	logic [NUM_CH-1:0][ADDR_W-1:0] ch_address;
	logic [NUM_CH-1:0][PAGE_W-1:0] page;

	dma_regs #(
		.NUM_CH(NUM_CH),
		.DATA_W(DATA_W),
		.PAGE_W(PAGE_W)
	) u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.io_address(io_address),
		.io_read(io_read),
		.io_write(io_write),
		.io_cs(io_cs),
		.io_page_cs(io_page_cs),
		.io_writedata(io_writedata),
		.io_readdata(io_readdata),
		.chan_rdata(chan_rdata),
		.tc_int(tc_int),
		.auto_init(auto_init),
		.dreq(dreq),
		.reg_write(reg_write),
		.ff(ff),
		.ch_clear(ch_clear),
		.disabled(disabled),
		.req_active(req_active),
		.page(page)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
		dma_chan #(
			.CH_NUM(i),
			.DATA_W(DATA_W),
			.ADDR_W(ADDR_W)
		) u_chan (
			.clk(clk),
			.rst_n(rst_n),
			.ch_clear(ch_clear),
			.io_address(io_address),
			.io_writedata(io_writedata),
			.reg_write(reg_write),
			.ff(ff),
			.grant(grant[i]),
			.dev_wdata_ch(dev_wdata[i]),
			.mem_readdata(mem_readdata),
			.mem_readdatavalid(mem_readdatavalid),
			.mem_waitrequest(mem_waitrequest),
			.rdata(chan_rdata[i]),
			.busy(busy[i]),
			.auto_init(auto_init[i]),
			.tc_int(tc_int[i]),
			.dack_ch(dack[i]),
			.tc_ch(tc[i]),
			.dev_rdata_ch(dev_rdata[i]),
			.ch_address(ch_address[i]),
			.ch_read(ch_read[i]),
			.ch_write(ch_write[i]),
			.ch_wdata(ch_wdata[i])
		);
	end

	dma_mem_port #(
		.NUM_CH(NUM_CH),
		.DATA_W(DATA_W),
		.ADDR_W(ADDR_W),
		.PAGE_W(PAGE_W),
		.MEM_ADDR_W(MEM_ADDR_W)
	) u_mem_port (
		.clk(clk),
		.rst_n(rst_n),
		.req_active(req_active),
		.disabled(disabled),
		.busy(busy),
		.page(page),
		.ch_address(ch_address),
		.ch_read(ch_read),
		.ch_write(ch_write),
		.ch_wdata(ch_wdata),
		.grant(grant),
		.mem_address(mem_address),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_writedata(mem_writedata)
	);

endmodule

// ==== project.f ====
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/dma_chan.sv
hdl/dma_mem_port.sv
hdl/dma_top.sv
tests/dma_mem_model.sv
tests/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the DMA controller testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module dma_tb -f project.f

out=$(./obj_dir/Vdma_tb)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"

// ==== tests/dma_mem_model.sv ====
// ********************
// memory model for the DMA testbench
// random wait-request of 0 to 3 cycles per access
// read data is the low address byte XOR 8'h5A
// and the last write is kept for the checks
// ********************

`timescale 1ns/10ps

module dma_mem_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [23:0] mem_address,
	input  logic        mem_read,
	input  logic        mem_write,
	input  logic [7:0]  mem_writedata,
	output logic [7:0]  mem_readdata,
	output logic        mem_readdatavalid,
	output logic        mem_waitrequest,
	output logic [23:0] last_wr_addr,
	output logic [7:0]  last_wr_data
);

	integer     seed = 32'h32d7445f;
	logic [1:0] wait_left;
	logic       accept;

	assign mem_waitrequest = (mem_read | mem_write) && wait_left != 2'd0;
	assign accept          = (mem_read | mem_write) && !mem_waitrequest;

	always @(posedge clk) begin
		if (!rst_n) begin
			wait_left         <= 2'd0;
			mem_readdata      <= '0;
			mem_readdatavalid <= 1'b0;
			last_wr_addr      <= '0;
			last_wr_data      <= '0;
		end else begin
			if (!(mem_read | mem_write))
				wait_left <= 2'($random(seed));  // a fresh stall length for the next access
			else if (wait_left != 2'd0)
				wait_left <= wait_left - 2'd1;
			mem_readdatavalid <= accept && mem_read;  // data comes one cycle after the accept
			if (accept && mem_read)
				mem_readdata <= mem_address[7:0] ^ 8'h5A;
			if (accept && mem_write) begin
				last_wr_addr <= mem_address;
				last_wr_data <= mem_writedata;
			end
		end
	end

endmodule

// ==== tests/dma_tb.sv ====
// ********************
// testbench of the four-channel DMA controller
// clock and reset, a stimulus table applied in a loop,
// register, transfer and masking checks with result lines
// ********************

`timescale 1ns/10ps

module dma_tb;

	localparam int         MAX_ROWS  = 64;
	localparam int         TIMEOUT   = 40;  // cycles allowed for any single wait
	localparam int         QUIET_CYC = 30;
	localparam logic [1:0] OP_WR     = 2'd0;
	localparam logic [1:0] OP_RD     = 2'd1;
	localparam logic [1:0] OP_XFER   = 2'd2;
	localparam logic [1:0] OP_QUIET  = 2'd3;  // hold dreq and expect nothing to happen

	typedef struct packed {
		logic [2:0]  test;
		logic [1:0]  op;
		logic        page;   // page registers instead of controller registers
		logic [3:0]  addr;   // port offset, or the dreq bits of a transfer
		logic [7:0]  data;   // written byte, expected byte or device byte
		logic [1:0]  ch;
		logic        wr;     // device to memory
		logic [23:0] maddr;
		logic        tc;
	} row_t;

	logic            clk;
	logic            rst_n;
	logic [3:0]      io_address;
	logic            io_read;
	logic            io_write;
	logic            io_cs;
	logic            io_page_cs;
	logic [7:0]      io_writedata;
	logic [7:0]      io_readdata;
	logic [23:0]     mem_address;
	logic            mem_read;
	logic            mem_write;
	logic [7:0]      mem_writedata;
	logic [7:0]      mem_readdata;
	logic            mem_readdatavalid;
	logic            mem_waitrequest;
	logic [3:0]      dreq;
	logic [3:0]      dack;
	logic [3:0]      tc;
	logic [3:0][7:0] dev_wdata;
	logic [3:0][7:0] dev_rdata;
	logic [23:0]     last_wr_addr;
	logic [7:0]      last_wr_data;

	row_t rows [MAX_ROWS];
	int   n_rows;
	int   checks;
	int   errors;
	int   test_checks;
	int   test_errs;

	dma_top dut (.*);

	dma_mem_model mem (.*);

	always #50 clk = ~clk;

	// ********************
	// helpers

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		test_checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("FAIL at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic note_error(input string msg);
		errors++;
		test_errs++;
		$display("%s", msg);
	endtask

	task automatic add_row(input logic [2:0] t, input logic [1:0] op, input logic pg,
		input logic [3:0] a, input logic [7:0] d, input logic [1:0] ch, input logic wr,
		input logic [23:0] maddr, input logic exp_tc);
		rows[n_rows] = {t, op, pg, a, d, ch, wr, maddr, exp_tc};
		n_rows++;
	endtask

	function automatic string test_name(input logic [2:0] t);
		case (t)
			3'd1:    return "reset state";
			3'd2:    return "address and count programming";
			3'd3:    return "memory-read transfer";
			3'd4:    return "memory-write transfer";
			3'd5:    return "priority and auto-init";
			default: return "master clear and masking";
		endcase
	endfunction

	// every port access starts and ends on a falling edge, with an idle cycle after it
	task automatic write_port(input logic pg, input logic [3:0] a, input logic [7:0] d);
		io_cs        = !pg;
		io_page_cs   = pg;
		io_write     = 1'b1;
		io_address   = a;
		io_writedata = d;
		@(negedge clk);
		io_write   = 1'b0;
		io_cs      = 1'b0;
		io_page_cs = 1'b0;
		@(negedge clk);
	endtask

	task automatic read_port(input logic pg, input logic [3:0] a, output logic [7:0] d);
		io_cs      = !pg;
		io_page_cs = pg;
		io_read    = 1'b1;
		io_address = a;
		@(negedge clk);
		d          = io_readdata;  // loaded on the edge just passed
		io_read    = 1'b0;
		io_cs      = 1'b0;
		io_page_cs = 1'b0;
		@(negedge clk);
	endtask

	task automatic run_xfer(input row_t r);
		int         n;
		logic [3:0] one;
		one           = 4'b0001 << r.ch;
		dreq          = dreq | r.addr;
		dev_wdata[r.ch] = r.data;
		n = 0;
		while (!(mem_read || mem_write) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n == TIMEOUT)
			note_error($sformatf("timeout: no memory access for channel %0d", r.ch));
		else begin
			check_value("mem_read", 32'(mem_read), 32'(!r.wr));
			check_value("mem_write", 32'(mem_write), 32'(r.wr));
			check_value("mem_address", 32'(mem_address), 32'(r.maddr));
		end
		n = 0;
		while (dack == 4'b0000 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		dreq = dreq & ~one;  // one byte per request
		if (n == TIMEOUT)
			note_error($sformatf("timeout: no dack for channel %0d", r.ch));
		else begin
			check_value("dack", 32'(dack), 32'(one));
			if (r.wr) begin
				check_value("last write address", 32'(last_wr_addr), 32'(r.maddr));
				check_value("last write data", 32'(last_wr_data), 32'(r.data));
			end else
				check_value("dev_rdata", 32'(dev_rdata[r.ch]), 32'(r.data));
			@(negedge clk);
			check_value("tc", 32'(tc), 32'(r.tc ? one : 4'b0000));  // tc trails dack by a cycle
		end
	endtask

	task automatic run_quiet(input row_t r);
		logic seen;
		seen = 1'b0;
		dreq = dreq | r.addr;
		for (int n = 0; n < QUIET_CYC; n++) begin
			if (mem_read || mem_write || dack != 4'b0000)
				seen = 1'b1;
			@(negedge clk);
		end
		check_value("dack or memory strobe", 32'(seen), 32'd0);
		dreq = dreq & ~r.addr;
	endtask

	// ********************
	// stimulus table

	task automatic build_table();
		//      test  op        pg    addr   data   ch    wr    mem address  tc
		add_row(3'd1, OP_RD,    1'b0, 4'd15, 8'hFF, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd1, OP_RD,    1'b0, 4'd8,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd1, OP_QUIET, 1'b0, 4'hF,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_WR,    1'b0, 4'd12, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_WR,    1'b0, 4'd2,  8'h34, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_WR,    1'b0, 4'd2,  8'h12, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_WR,    1'b0, 4'd3,  8'h78, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_WR,    1'b0, 4'd3,  8'h56, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_WR,    1'b0, 4'd12, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_RD,    1'b0, 4'd2,  8'h34, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_RD,    1'b0, 4'd2,  8'h12, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_RD,    1'b0, 4'd3,  8'h78, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd2, OP_RD,    1'b0, 4'd3,  8'h56, 2'd0, 1'b0, 24'h000000, 1'b0);
		// channel 2 reads memory upwards from 12:0100, three bytes
		add_row(3'd3, OP_WR,    1'b1, 4'd1,  8'h12, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_RD,    1'b1, 4'd1,  8'h12, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd12, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd4,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd4,  8'h01, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd5,  8'h02, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd5,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd11, 8'h4A, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_WR,    1'b0, 4'd10, 8'h02, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_XFER,  1'b0, 4'h4,  8'h5A, 2'd2, 1'b0, 24'h120100, 1'b0);
		add_row(3'd3, OP_XFER,  1'b0, 4'h4,  8'h5B, 2'd2, 1'b0, 24'h120101, 1'b0);
		add_row(3'd3, OP_XFER,  1'b0, 4'h4,  8'h58, 2'd2, 1'b0, 24'h120102, 1'b1);
		add_row(3'd3, OP_RD,    1'b0, 4'd8,  8'h04, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_RD,    1'b0, 4'd15, 8'hFF, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd3, OP_RD,    1'b0, 4'd8,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		// channel 3 writes memory downwards from 34:0210, two bytes
		add_row(3'd4, OP_WR,    1'b1, 4'd2,  8'h34, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd12, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd6,  8'h10, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd6,  8'h02, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd7,  8'h01, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd7,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd11, 8'h67, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_WR,    1'b0, 4'd10, 8'h03, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd4, OP_XFER,  1'b0, 4'h8,  8'hA5, 2'd3, 1'b1, 24'h340210, 1'b0);
		add_row(3'd4, OP_XFER,  1'b0, 4'h8,  8'h3C, 2'd3, 1'b1, 24'h34020F, 1'b1);
		// channel 0 auto-init with count 0 against channel 1 at the same time
		add_row(3'd5, OP_WR,    1'b1, 4'd7,  8'h56, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd12, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd0,  8'h40, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd0,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd1,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd1,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd11, 8'h58, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd11, 8'h49, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_WR,    1'b0, 4'd15, 8'h0C, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_XFER,  1'b0, 4'h3,  8'h1A, 2'd0, 1'b0, 24'h560040, 1'b1);
		add_row(3'd5, OP_XFER,  1'b0, 4'h2,  8'h6E, 2'd1, 1'b0, 24'h001234, 1'b0);
		add_row(3'd5, OP_RD,    1'b0, 4'd15, 8'hFC, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd5, OP_XFER,  1'b0, 4'h1,  8'h1A, 2'd0, 1'b0, 24'h560040, 1'b1);
		add_row(3'd6, OP_WR,    1'b0, 4'd10, 8'h05, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd6, OP_QUIET, 1'b0, 4'h2,  8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd6, OP_WR,    1'b0, 4'd13, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd6, OP_RD,    1'b0, 4'd15, 8'hFF, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd6, OP_WR,    1'b0, 4'd14, 8'h00, 2'd0, 1'b0, 24'h000000, 1'b0);
		add_row(3'd6, OP_XFER,  1'b0, 4'h2,  8'h6F, 2'd1, 1'b0, 24'h001235, 1'b0);
	endtask

	// ********************
	// main sequence

	initial begin
		row_t       r;
		logic [7:0] got;
		clk          = 1'b0;
		rst_n        = 1'b0;
		io_address   = 4'd0;
		io_read      = 1'b0;
		io_write     = 1'b0;
		io_cs        = 1'b0;
		io_page_cs   = 1'b0;
		io_writedata = 8'h00;
		dreq         = 4'b0000;
		dev_wdata    = '0;
		n_rows       = 0;
		checks       = 0;
		errors       = 0;
		test_checks  = 0;
		test_errs    = 0;
		build_table();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < n_rows; i++) begin
			r = rows[i];
			case (r.op)
				OP_WR:   write_port(r.page, r.addr, r.data);
				OP_RD: begin
					read_port(r.page, r.addr, got);
					check_value(r.page ? "page readback" : "io_readdata", 32'(got), 32'(r.data));
				end
				OP_XFER: run_xfer(r);
				default: run_quiet(r);
			endcase
			if (i == n_rows - 1 || rows[i + 1].test != r.test) begin
				$display("test %0d %s: %s, %0d checks", r.test, test_name(r.test),
					test_errs == 0 ? "ok" : "failed", test_checks);
				test_checks = 0;
				test_errs   = 0;
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
